//--- rtl/dcache_pkg.sv
// Shared constants and types of the data cache
// Widths, way count, word type, tag write kinds and controller states

package dcache_pkg;

   // ******************************
   // Bus widths
   // ******************************

   // Byte address width of the load/store port
   localparam int ADDR_WIDTH = 32;

   // Width of one data word
   localparam int DATA_WIDTH = 32;

   // One byte select per byte of a word
   localparam int BSEL_WIDTH = DATA_WIDTH / 8;

   // Associativity is fixed, the LRU state is one bit per set
   localparam int NUM_WAYS = 2;

   // ******************************
   // Types
   // ******************************

   typedef logic [DATA_WIDTH-1:0] word_t;

   // Kinds of tag entry update requested by the controller
   typedef enum logic [1:0] {
      TAG_TOUCH   = 2'd0,
      TAG_DIRTY   = 2'd1,
      TAG_INVAL   = 2'd2,
      TAG_INSTALL = 2'd3
   } tag_wr_kind_t;

   // Controller states, one-hot
   typedef enum logic [4:0] {
      IDLE      = 5'b00001,
      LOOKUP    = 5'b00010,
      DUMP      = 5'b00100,
      REFILL    = 5'b01000,
      FILL_DONE = 5'b10000
   } ctrl_state_t;

endpackage

//--- rtl/dcache_tag_if.sv
// Lookup and tag update signals between the cache controller and the tag store
`timescale 1ns/1ps

interface dcache_tag_if #(
   parameter int SET_WIDTH = 6,
   parameter int TAG_WIDTH = 22
);
   // Lookup request, driven every cycle from the CPU address
   logic [SET_WIDTH-1:0]             index;
   logic [TAG_WIDTH-1:0]             cmp_tag;
   // Tag entry update for the indexed set
   logic                             we;
   dcache_pkg::tag_wr_kind_t         wr_kind;
   // Result of the lookup, one cycle after the index
   logic [dcache_pkg::NUM_WAYS-1:0]  way_hit;
   logic                             hit;
   logic [dcache_pkg::NUM_WAYS-1:0]  victim;
   logic                             victim_dirty;
   logic [TAG_WIDTH-1:0]             victim_tag;
   // Low while the sets are cleared after reset
   logic                             ready;

   modport ctrl (
      output index, cmp_tag, we, wr_kind,
      input  way_hit, hit, victim, victim_dirty, victim_tag, ready
   );

   modport store (
      input  index, cmp_tag, we, wr_kind,
      output way_hit, hit, victim, victim_dirty, victim_tag, ready
   );
endinterface

//--- rtl/dcache_sram.sv
// Single clock dual-port memory with registered read and write bypass
`timescale 1ns/1ps

module dcache_sram #(
   parameter type payload_t = logic [31:0],
   parameter int  ADDR_BITS = 6
) (
   input  logic                 clk,
   input  logic [ADDR_BITS-1:0] raddr_i,
   input  logic [ADDR_BITS-1:0] waddr_i,
   input  logic                 we_i,
   input  payload_t             din_i,
   output payload_t             dout_o
);

   payload_t mem [2**ADDR_BITS];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // A write to the address being read is forwarded, so a
      // read-modify-write in the next cycle sees the new value
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

//--- rtl/dcache_tag_store.sv
// Tag memory with hit compare, valid and dirty flags and one LRU bit per set
// Includes the reset sweep that clears every set
`timescale 1ns/1ps

module dcache_tag_store #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic         clk,
   input  logic         rst,
   dcache_tag_if.store  tag
);

   localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   typedef struct packed {
      logic [TAG_WIDTH-1:0] tag;
      logic                 valid;
      logic                 dirty;
   } way_rec_t;

   // The LRU bit holds the index of the least recently used way
   typedef struct packed {
      logic                                lru;
      way_rec_t [dcache_pkg::NUM_WAYS-1:0] way;
   } tag_entry_t;

   tag_entry_t           rd_entry;
   tag_entry_t           wr_entry;
   logic                 wr_en;
   logic [SET_WIDTH-1:0] wr_set;
   logic [SET_WIDTH-1:0] sweep_set;
   logic                 sweeping;
   logic                 hit_way;

   // ******************************
   // Lookup result
   // ******************************

   for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_cmp
      assign tag.way_hit[w] = rd_entry.way[w].valid && (rd_entry.way[w].tag == tag.cmp_tag);
   end

   assign tag.hit = |tag.way_hit;
   // Index of the hitting way, two ways only
   assign hit_way = tag.way_hit[1];

   always_comb begin
      tag.victim = '0;
      tag.victim[rd_entry.lru] = 1'b1;
   end

   // Only a line that holds data needs a dump
   assign tag.victim_dirty = rd_entry.way[rd_entry.lru].valid && rd_entry.way[rd_entry.lru].dirty;
   assign tag.victim_tag = rd_entry.way[rd_entry.lru].tag;

   // ******************************
   // Entry update
   // ******************************

   always_comb begin
      wr_entry = rd_entry;
      case (tag.wr_kind)
         dcache_pkg::TAG_TOUCH: begin
            wr_entry.lru = !hit_way;
         end
         dcache_pkg::TAG_DIRTY: begin
            wr_entry.way[hit_way].dirty = 1'b1;
            wr_entry.lru = !hit_way;
         end
         dcache_pkg::TAG_INVAL: begin
            // LRU stays put, so the same way is still the victim at install
            wr_entry.way[rd_entry.lru].valid = 1'b0;
            wr_entry.way[rd_entry.lru].dirty = 1'b0;
         end
         default: begin
            wr_entry.way[rd_entry.lru].tag = tag.cmp_tag;
            wr_entry.way[rd_entry.lru].valid = 1'b1;
            wr_entry.way[rd_entry.lru].dirty = 1'b0;
            wr_entry.lru = !rd_entry.lru;
         end
      endcase
      if (sweeping) begin
         wr_entry = '0;
      end
   end

   // The sweep owns the write port until every set has been cleared
   assign wr_en = sweeping || tag.we;
   assign wr_set = sweeping ? sweep_set : tag.index;
   assign tag.ready = !sweeping;

   always_ff @(posedge clk) begin
      if (rst) begin
         sweeping <= 1'b1;
         sweep_set <= '0;
      end else if (sweeping) begin
         sweep_set <= sweep_set + 1'b1;
         if (&sweep_set) begin
            sweeping <= 1'b0;
         end
      end
   end

   dcache_sram #(
      .payload_t (tag_entry_t),
      .ADDR_BITS (SET_WIDTH)
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (tag.index),
      .waddr_i (wr_set),
      .we_i    (wr_en),
      .din_i   (wr_entry),
      .dout_o  (rd_entry)
   );

   // A refill never installs a tag that already hits in the other way
   a_way_hit_onehot: assert property (@(posedge clk) disable iff (rst || !tag.ready)
      $onehot0(tag.way_hit));

endmodule

//--- rtl/dcache_data_array.sv
// Way data memories, byte merge for CPU writes and output way select
`timescale 1ns/1ps

module dcache_data_array #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                                 clk,
   input  logic [SET_WIDTH+BLOCK_WIDTH-3:0]     rd_adr_i,
   input  logic [SET_WIDTH+BLOCK_WIDTH-3:0]     wr_adr_i,
   input  logic [dcache_pkg::NUM_WAYS-1:0]      way_we_i,
   input  logic                                 sel_cpu_i,
   input  dcache_pkg::word_t                    cpu_dat_i,
   input  logic [dcache_pkg::BSEL_WIDTH-1:0]    cpu_bsel_i,
   input  dcache_pkg::word_t                    refill_dat_i,
   input  logic [dcache_pkg::NUM_WAYS-1:0]      out_way_i,
   output dcache_pkg::word_t                    dat_o
);

   // Word address inside a way, set and word index
   localparam int WORD_ADR_BITS = SET_WIDTH + BLOCK_WIDTH - 2;

   dcache_pkg::word_t way_dout [dcache_pkg::NUM_WAYS];
   dcache_pkg::word_t merged;
   dcache_pkg::word_t wr_dat;

   // Bytes not selected keep the value read out in the lookup cycle
   always_comb begin
      for (int b = 0; b < dcache_pkg::BSEL_WIDTH; b++) begin
         merged[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : dat_o[8*b +: 8];
      end
   end

   // Refill words are written unchanged
   assign wr_dat = sel_cpu_i ? merged : refill_dat_i;

   for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
      dcache_sram #(
         .payload_t (dcache_pkg::word_t),
         .ADDR_BITS (WORD_ADR_BITS)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (rd_adr_i),
         .waddr_i (wr_adr_i),
         .we_i    (way_we_i[w]),
         .din_i   (wr_dat),
         .dout_o  (way_dout[w])
      );
   end

   // Hit way on lookup, victim way during a dump
   always_comb begin
      dat_o = '0;
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
         if (out_way_i[w]) begin
            dat_o = way_dout[w];
         end
      end
   end

endmodule

//--- rtl/dcache_ctrl.sv
// Cache FSM for lookup, write hit, victim dump and line refill
// Also forms the data array and memory addresses
`timescale 1ns/1ps

module dcache_ctrl #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 cpu_req_i,
   input  logic                                 cpu_we_i,
   input  logic [dcache_pkg::ADDR_WIDTH-1:0]    cpu_adr_i,
   output logic                                 cpu_ack_o,
   dcache_tag_if.ctrl                           tag,
   output logic [SET_WIDTH+BLOCK_WIDTH-3:0]     rd_adr_o,
   output logic [SET_WIDTH+BLOCK_WIDTH-3:0]     wr_adr_o,
   output logic [dcache_pkg::NUM_WAYS-1:0]      way_we_o,
   output logic                                 sel_cpu_o,
   output logic [dcache_pkg::NUM_WAYS-1:0]      out_way_o,
   output logic [dcache_pkg::ADDR_WIDTH-1:0]    mem_adr_o,
   output logic                                 mem_wr_o,
   output logic                                 mem_rd_req_o,
   input  logic                                 mem_rd_valid_i
);

   localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   localparam int WORD_BITS = BLOCK_WIDTH - 2;

   dcache_pkg::ctrl_state_t          state_q;
   dcache_pkg::ctrl_state_t          state_d;
   logic [TAG_WIDTH-1:0]             cpu_tag;
   logic [SET_WIDTH-1:0]             cpu_set;
   logic [WORD_BITS-1:0]             cpu_word;
   // The extra MSB marks the end of the dump
   logic [WORD_BITS:0]               dump_cnt;
   logic [WORD_BITS-1:0]             dump_wr_idx;
   logic [WORD_BITS-1:0]             refill_cnt;
   logic [dcache_pkg::NUM_WAYS-1:0]  victim_way_q;
   logic [TAG_WIDTH-1:0]             victim_tag_q;

   assign cpu_tag = cpu_adr_i[dcache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
   assign cpu_set = cpu_adr_i[BLOCK_WIDTH +: SET_WIDTH];
   assign cpu_word = cpu_adr_i[2 +: WORD_BITS];

   // The CPU holds its address, so the lookup index is always valid
   assign tag.index = cpu_set;
   assign tag.cmp_tag = cpu_tag;

   // ******************************
   // Next state
   // ******************************

   always_comb begin
      state_d = state_q;
      case (state_q)
         dcache_pkg::IDLE: begin
            if (cpu_req_i && tag.ready) begin
               state_d = dcache_pkg::LOOKUP;
            end
         end
         dcache_pkg::LOOKUP: begin
            if (tag.hit) begin
               state_d = dcache_pkg::IDLE;
            end else if (tag.victim_dirty) begin
               state_d = dcache_pkg::DUMP;
            end else begin
               state_d = dcache_pkg::REFILL;
            end
         end
         dcache_pkg::DUMP: begin
            if (dump_cnt[WORD_BITS]) begin
               state_d = dcache_pkg::REFILL;
            end
         end
         dcache_pkg::REFILL: begin
            if (mem_rd_valid_i && (&refill_cnt)) begin
               state_d = dcache_pkg::FILL_DONE;
            end
         end
         // The tag is installed here, then the lookup is repeated
         dcache_pkg::FILL_DONE: state_d = dcache_pkg::LOOKUP;
         default: state_d = dcache_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= dcache_pkg::IDLE;
         dump_cnt <= '0;
         refill_cnt <= '0;
         victim_way_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == dcache_pkg::LOOKUP && !tag.hit) begin
            victim_way_q <= tag.victim;
            dump_cnt <= '0;
            refill_cnt <= '0;
         end
         if (state_q == dcache_pkg::DUMP) begin
            dump_cnt <= dump_cnt + 1'b1;
         end
         if (state_q == dcache_pkg::REFILL && mem_rd_valid_i) begin
            refill_cnt <= refill_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == dcache_pkg::LOOKUP && !tag.hit) begin
         victim_tag_q <= tag.victim_tag;
      end
   end

   // ******************************
   // Tag and data array control
   // ******************************

   always_comb begin
      tag.we = 1'b0;
      tag.wr_kind = dcache_pkg::TAG_TOUCH;
      if (state_q == dcache_pkg::LOOKUP && tag.hit) begin
         tag.we = 1'b1;
         tag.wr_kind = cpu_we_i ? dcache_pkg::TAG_DIRTY : dcache_pkg::TAG_TOUCH;
      end else if (state_q == dcache_pkg::REFILL) begin
         // Repeating this every refill cycle leaves the same entry
         tag.we = 1'b1;
         tag.wr_kind = dcache_pkg::TAG_INVAL;
      end else if (state_q == dcache_pkg::FILL_DONE) begin
         tag.we = 1'b1;
         tag.wr_kind = dcache_pkg::TAG_INSTALL;
      end
   end

   always_comb begin
      way_we_o = '0;
      if (state_q == dcache_pkg::LOOKUP && cpu_we_i) begin
         way_we_o = tag.way_hit;
      end else if (state_q == dcache_pkg::REFILL && mem_rd_valid_i) begin
         way_we_o = victim_way_q;
      end
   end

   // The dump reads one word ahead of the word being written out
   assign rd_adr_o = (state_q == dcache_pkg::DUMP) ? {cpu_set, dump_cnt[WORD_BITS-1:0]}
                                                   : {cpu_set, cpu_word};
   assign wr_adr_o = (state_q == dcache_pkg::REFILL) ? {cpu_set, refill_cnt}
                                                     : {cpu_set, cpu_word};
   assign sel_cpu_o = (state_q == dcache_pkg::LOOKUP);
   assign out_way_o = (state_q == dcache_pkg::DUMP) ? victim_way_q : tag.way_hit;

   assign cpu_ack_o = (state_q == dcache_pkg::LOOKUP) && tag.hit;

   // ******************************
   // Memory side
   // ******************************

   assign dump_wr_idx = dump_cnt[WORD_BITS-1:0] - 1'b1;
   assign mem_wr_o = (state_q == dcache_pkg::DUMP) && (dump_cnt != '0);
   assign mem_rd_req_o = (state_q == dcache_pkg::REFILL);
   assign mem_adr_o = (state_q == dcache_pkg::DUMP) ?
                      {victim_tag_q, cpu_set, dump_wr_idx, 2'b00} :
                      {cpu_tag, cpu_set, {BLOCK_WIDTH{1'b0}}};

   // A refill word that arrives during a dump would be lost
   a_dump_refill_excl: assert property (@(posedge clk) disable iff (rst)
      !(mem_wr_o && (mem_rd_req_o || mem_rd_valid_i)));

   // An acknowledge only answers a request that the CPU still holds
   a_ack_in_lookup: assert property (@(posedge clk) disable iff (rst)
      cpu_ack_o |-> (state_q == dcache_pkg::LOOKUP) && cpu_req_i);

endmodule

//--- rtl/dcache_top.sv
// Top level of the two-way write-back data cache
// Joins controller, tag store and data array to the CPU and memory ports
`timescale 1ns/1ps

module dcache_top #(
   parameter int SET_WIDTH   = 6,
   parameter int BLOCK_WIDTH = 4
) (
   input  logic                                 clk,
   input  logic                                 rst,
   // CPU load/store port
   input  logic                                 cpu_req_i,
   input  logic                                 cpu_we_i,
   input  logic [dcache_pkg::ADDR_WIDTH-1:0]    cpu_adr_i,
   input  dcache_pkg::word_t                    cpu_dat_i,
   input  logic [dcache_pkg::BSEL_WIDTH-1:0]    cpu_bsel_i,
   output logic                                 cpu_ack_o,
   output dcache_pkg::word_t                    cpu_dat_o,
   // Memory port
   output logic [dcache_pkg::ADDR_WIDTH-1:0]    mem_adr_o,
   output logic                                 mem_wr_o,
   output dcache_pkg::word_t                    mem_wr_dat_o,
   output logic                                 mem_rd_req_o,
   input  dcache_pkg::word_t                    mem_rd_dat_i,
   input  logic                                 mem_rd_valid_i
);

   localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   logic [SET_WIDTH+BLOCK_WIDTH-3:0] rd_adr;
   logic [SET_WIDTH+BLOCK_WIDTH-3:0] wr_adr;
   logic [dcache_pkg::NUM_WAYS-1:0]  way_we;
   logic                             sel_cpu;
   logic [dcache_pkg::NUM_WAYS-1:0]  out_way;
   dcache_pkg::word_t                way_dat;

   dcache_tag_if #(.SET_WIDTH(SET_WIDTH), .TAG_WIDTH(TAG_WIDTH)) u_tag_if ();

   dcache_ctrl #(.SET_WIDTH(SET_WIDTH), .BLOCK_WIDTH(BLOCK_WIDTH)) u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .cpu_ack_o      (cpu_ack_o),
      .tag            (u_tag_if.ctrl),
      .rd_adr_o       (rd_adr),
      .wr_adr_o       (wr_adr),
      .way_we_o       (way_we),
      .sel_cpu_o      (sel_cpu),
      .out_way_o      (out_way),
      .mem_adr_o      (mem_adr_o),
      .mem_wr_o       (mem_wr_o),
      .mem_rd_req_o   (mem_rd_req_o),
      .mem_rd_valid_i (mem_rd_valid_i)
   );

   dcache_tag_store #(.SET_WIDTH(SET_WIDTH), .BLOCK_WIDTH(BLOCK_WIDTH)) u_tag_store (
      .clk (clk),
      .rst (rst),
      .tag (u_tag_if.store)
   );

   dcache_data_array #(.SET_WIDTH(SET_WIDTH), .BLOCK_WIDTH(BLOCK_WIDTH)) u_data_array (
      .clk          (clk),
      .rd_adr_i     (rd_adr),
      .wr_adr_i     (wr_adr),
      .way_we_i     (way_we),
      .sel_cpu_i    (sel_cpu),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_bsel_i   (cpu_bsel_i),
      .refill_dat_i (mem_rd_dat_i),
      .out_way_i    (out_way),
      .dat_o        (way_dat)
   );

   // Read data and dumped words share the data array output
   assign cpu_dat_o = way_dat;
   assign mem_wr_dat_o = way_dat;

endmodule

//--- testbench/tb_clock_gen.sv
// Clock and reset generator for the cache testbench
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   // 8 ns period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // Reset is held for 8 cycles and released just after an edge
   initial begin
      rst_o = 1'b1;
      repeat (8) @(posedge clk_o);
      #1 rst_o = 1'b0;
   end

endmodule

//--- testbench/tb_mem_model.sv
// Backing memory for the cache with a 1 KB window of 256 words
// Answers refill requests word by word and stores dumped words
`timescale 1ns/1ps

module tb_mem_model (
   input  logic        clk,
   input  logic [31:0] mem_adr_i,
   input  logic        mem_wr_i,
   input  logic [31:0] mem_wr_dat_i,
   input  logic        mem_rd_req_i,
   output logic [31:0] mem_rd_dat_o,
   output logic        mem_rd_valid_o
);

   logic [31:0] mem [256];

   // Address bits 11:10 pick the tag and bits 7:2 pick set and word
   function automatic logic [7:0] word_idx(input logic [31:0] adr);
      return {adr[11:10], adr[7:2]};
   endfunction

   // Start value depends on every bit of the byte address
   function automatic logic [31:0] init_word(input logic [7:0] idx);
      logic [31:0] a;
      a = {20'd0, idx[7:6], 2'b00, idx[5:0], 2'b00};
      return (a * 32'h0100_0193) ^ 32'h3c5a_0f96 ^ {a[15:0], a[31:16]};
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = init_word(i[7:0]);
      end
   end

   // Every strobe carries one word of a dumped line
   always @(negedge clk) begin
      if (mem_wr_i) begin
         mem[word_idx(mem_adr_i)] = mem_wr_dat_i;
      end
   end

   // Refill answer with a lead of a few cycles and a gap before every word
   initial begin : answer
      logic [31:0] base;
      mem_rd_valid_o = 1'b0;
      mem_rd_dat_o = '0;
      forever begin
         @(negedge clk);
         if (mem_rd_req_i) begin
            base = mem_adr_i;
            repeat (3) @(posedge clk);
            for (int i = 0; i < 4; i++) begin
               @(posedge clk);
               #1 mem_rd_valid_o = 1'b1;
               mem_rd_dat_o = mem[word_idx(base) + i];
               @(posedge clk);
               #1 mem_rd_valid_o = 1'b0;
            end
         end
      end
   end

endmodule

//--- testbench/dcache_checker.sv
// Watches the DUT ports and keeps the reference memory image
// Compares read data and dumped words, counts acks, dumps and refills
`timescale 1ns/1ps

module dcache_checker (
   input  logic        clk,
   input  logic        rst,
   input  logic        cpu_we_i,
   input  logic [31:0] cpu_adr_i,
   input  logic [31:0] cpu_dat_i,
   input  logic [3:0]  cpu_bsel_i,
   input  logic        cpu_ack_i,
   input  logic [31:0] cpu_rd_dat_i,
   input  logic [31:0] mem_adr_i,
   input  logic        mem_wr_i,
   input  logic [31:0] mem_wr_dat_i,
   input  logic        mem_rd_req_i,
   output int          err_cnt_o,
   output int          ack_cnt_o,
   output int          dump_cnt_o,
   output int          refill_cnt_o
);

   logic [31:0] image [256];
   logic        rd_req_q;

   function automatic logic [7:0] word_idx(input logic [31:0] adr);
      return {adr[11:10], adr[7:2]};
   endfunction

   function automatic logic [31:0] init_word(input logic [7:0] idx);
      logic [31:0] a;
      a = {20'd0, idx[7:6], 2'b00, idx[5:0], 2'b00};
      return (a * 32'h0100_0193) ^ 32'h3c5a_0f96 ^ {a[15:0], a[31:16]};
   endfunction

   // A word is its start value with all later CPU writes merged in
   function automatic logic [31:0] ref_word(input logic [31:0] adr);
      return image[word_idx(adr)];
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  bsel);
      logic [31:0] r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) begin
            r[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return r;
   endfunction

   initial begin
      err_cnt_o = 0;
      ack_cnt_o = 0;
      dump_cnt_o = 0;
      refill_cnt_o = 0;
      rd_req_q = 1'b0;
      for (int i = 0; i < 256; i++) begin
         image[i] = init_word(i[7:0]);
      end
   end

   // ******************************
   // Sampling at the falling edge, where all DUT outputs are settled
   // ******************************

   always @(negedge clk) begin : watch
      logic [31:0] exp;
      if (!rst) begin
         if (cpu_ack_i) begin
            ack_cnt_o++;
            if (cpu_we_i) begin
               image[word_idx(cpu_adr_i)] =
                  merge_bytes(image[word_idx(cpu_adr_i)], cpu_dat_i, cpu_bsel_i);
            end else begin
               exp = ref_word(cpu_adr_i);
               if (cpu_rd_dat_i !== exp) begin
                  err_cnt_o++;
                  $display("[ERROR] %0t: read of %h returned %h, expected %h",
                           $time, cpu_adr_i, cpu_rd_dat_i, exp);
               end
            end
         end
         // Each dumped word must hold the latest written value
         if (mem_wr_i) begin
            dump_cnt_o++;
            exp = ref_word(mem_adr_i);
            if (mem_wr_dat_i !== exp) begin
               err_cnt_o++;
               $display("[ERROR] %0t: dump of %h wrote %h, expected %h",
                        $time, mem_adr_i, mem_wr_dat_i, exp);
            end
         end
         if (mem_rd_req_i && !rd_req_q) begin
            refill_cnt_o++;
         end
         rd_req_q = mem_rd_req_i;
      end
   end

endmodule

//--- testbench/tb_dcache.sv
// Testbench top for the data cache
// Directed tests for miss, merge, dump and LRU, then a random sequence
`timescale 1ns/1ps

module tb_dcache;

   // Total requests of all tests set the watchdog limit
   localparam int NUM_REQ = 319;
   localparam int TIMEOUT_NS = (NUM_REQ * 200 + 200) * 8;

   logic        clk;
   logic        rst;
   logic        cpu_req;
   logic        cpu_we;
   logic [31:0] cpu_adr;
   logic [31:0] cpu_dat;
   logic [3:0]  cpu_bsel;
   logic        cpu_ack;
   logic [31:0] cpu_rd_dat;
   logic [31:0] mem_adr;
   logic        mem_wr;
   logic [31:0] mem_wr_dat;
   logic        mem_rd_req;
   logic [31:0] mem_rd_dat;
   logic        mem_rd_valid;
   int          err_cnt;
   int          ack_cnt;
   int          dump_cnt;
   int          refill_cnt;
   int          fails;
   int          req_cnt;
   int          test_cnt;
   int          err_mark;
   int          ack_mark;
   int          req_mark;
   logic [31:0] lfsr;

   tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

   dcache_top u_dcache_top (
      .clk (clk), .rst (rst),
      .cpu_req_i (cpu_req), .cpu_we_i (cpu_we), .cpu_adr_i (cpu_adr),
      .cpu_dat_i (cpu_dat), .cpu_bsel_i (cpu_bsel),
      .cpu_ack_o (cpu_ack), .cpu_dat_o (cpu_rd_dat),
      .mem_adr_o (mem_adr), .mem_wr_o (mem_wr), .mem_wr_dat_o (mem_wr_dat),
      .mem_rd_req_o (mem_rd_req), .mem_rd_dat_i (mem_rd_dat),
      .mem_rd_valid_i (mem_rd_valid)
   );

   tb_mem_model u_mem (
      .clk (clk), .mem_adr_i (mem_adr), .mem_wr_i (mem_wr), .mem_wr_dat_i (mem_wr_dat),
      .mem_rd_req_i (mem_rd_req), .mem_rd_dat_o (mem_rd_dat), .mem_rd_valid_o (mem_rd_valid)
   );

   dcache_checker u_chk (
      .clk (clk), .rst (rst), .cpu_we_i (cpu_we), .cpu_adr_i (cpu_adr),
      .cpu_dat_i (cpu_dat), .cpu_bsel_i (cpu_bsel), .cpu_ack_i (cpu_ack),
      .cpu_rd_dat_i (cpu_rd_dat), .mem_adr_i (mem_adr), .mem_wr_i (mem_wr),
      .mem_wr_dat_i (mem_wr_dat), .mem_rd_req_i (mem_rd_req),
      .err_cnt_o (err_cnt), .ack_cnt_o (ack_cnt),
      .dump_cnt_o (dump_cnt), .refill_cnt_o (refill_cnt)
   );

   // Galois LFSR stepped once per random bit
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Byte address of a word inside the window of sets 0 to 15 and tags 0 to 3
   function automatic logic [31:0] adr_of(input int t, input int s, input int w);
      return (t << 10) | (s << 4) | (w << 2);
   endfunction

   // One CPU request, held until the acknowledge
   task automatic cpu_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] bsel);
      @(posedge clk);
      #1 cpu_req = 1'b1;
      cpu_we = we;
      cpu_adr = adr;
      cpu_dat = dat;
      cpu_bsel = bsel;
      req_cnt++;
      do @(negedge clk); while (!cpu_ack);
      @(posedge clk);
      #1 cpu_req = 1'b0;
   endtask

   task automatic expect_count(input string what, input int got, input int exp);
      if (got != exp) begin
         fails++;
         $display("[ERROR] %0t: expected %0d %s, got %0d", $time, exp, what, got);
      end
   endtask

   // Counts that the errors and acknowledges of the next test are measured from
   task automatic start_test();
      err_mark = fails + err_cnt;
      ack_mark = ack_cnt;
      req_mark = req_cnt;
   endtask

   task automatic report_test(input string name);
      expect_count("acknowledges", ack_cnt - ack_mark, req_cnt - req_mark);
      test_cnt++;
      $display("Test %0d %s done with %0d errors", test_cnt, name,
               fails + err_cnt - err_mark);
   endtask

   // Watchdog for a request that never completes
   initial begin
      #(TIMEOUT_NS);
      $display("Run timed out: the cache stopped acknowledging requests");
      $display("Some tests failed");
      $finish;
   end

   initial begin : stimulus
      int d0;
      logic [31:0] adr;
      cpu_req = 1'b0;
      cpu_we = 1'b0;
      cpu_adr = '0;
      cpu_dat = '0;
      cpu_bsel = '0;
      fails = 0;
      req_cnt = 0;
      test_cnt = 0;
      err_mark = 0;
      ack_mark = 0;
      req_mark = 0;
      lfsr = 32'h806f;
      @(negedge rst);

      // Read miss followed by hits in the same line
      start_test();
      for (int w = 0; w < 4; w++) begin
         cpu_access(1'b0, adr_of(0, 1, w), '0, '0);
      end
      report_test("read miss and hits");

      // Byte merge on a write hit
      start_test();
      cpu_access(1'b1, adr_of(0, 1, 2), 32'h1122_3344, 4'b0101);
      cpu_access(1'b0, adr_of(0, 1, 2), '0, '0);
      report_test("byte merge");

      // Dirty victim is dumped as four words
      start_test();
      cpu_access(1'b1, adr_of(0, 2, 1), 32'hdead_beef, 4'b1111);
      cpu_access(1'b0, adr_of(1, 2, 0), '0, '0);
      d0 = dump_cnt;
      cpu_access(1'b0, adr_of(2, 2, 3), '0, '0);
      expect_count("dump strobes", dump_cnt - d0, 4);
      cpu_access(1'b0, adr_of(0, 2, 1), '0, '0);
      report_test("dirty eviction");

      // Clean victim leaves without a dump
      start_test();
      cpu_access(1'b0, adr_of(0, 3, 0), '0, '0);
      cpu_access(1'b0, adr_of(1, 3, 0), '0, '0);
      d0 = dump_cnt;
      cpu_access(1'b0, adr_of(2, 3, 0), '0, '0);
      expect_count("dump strobes", dump_cnt - d0, 0);
      report_test("clean eviction");

      // A, B, A, C evicts B and keeps A
      start_test();
      cpu_access(1'b0, adr_of(0, 4, 0), '0, '0);
      cpu_access(1'b0, adr_of(1, 4, 0), '0, '0);
      cpu_access(1'b0, adr_of(0, 4, 1), '0, '0);
      cpu_access(1'b0, adr_of(2, 4, 0), '0, '0);
      d0 = refill_cnt;
      cpu_access(1'b0, adr_of(0, 4, 2), '0, '0);
      expect_count("refills for A", refill_cnt - d0, 0);
      d0 = refill_cnt;
      cpu_access(1'b0, adr_of(1, 4, 2), '0, '0);
      expect_count("refills for B", refill_cnt - d0, 1);
      report_test("LRU order");

      // Random mix over the whole window
      start_test();
      for (int i = 0; i < 300; i++) begin
         adr = adr_of(int'(rand_bits(2)), int'(rand_bits(4)), int'(rand_bits(2)));
         cpu_access(rand_bits(1) != 0, adr, rand_bits(32), rand_bits(4));
      end
      report_test("random mix");

      repeat (4) @(posedge clk);
      expect_count("acknowledges in total", ack_cnt, req_cnt);
      $display("Summary: %0d tests, %0d requests, %0d errors", test_cnt, req_cnt,
               fails + err_cnt);
      if (fails + err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- build.f
rtl/dcache_pkg.sv
rtl/dcache_tag_if.sv
rtl/dcache_sram.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_model.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dcache -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
grep -q "All tests passed" sim.log
